// File: hw/sifh_config.svh
`ifndef SIFH_CONFIG_SVH
`define SIFH_CONFIG_SVH

// ********************************************************************
// sizes of the histogram estimator
// ********************************************************************

// timestamp code width
`define TS_W 10
// bin index width, coarse and fine histograms share it
`define BIN_W 6

// pixel group
`define PIX_NUM 4
`define PIX_W 2

// stream order per pass
`define DATA_NUM 2
`define ACQ_NUM 4

// saturating count per bin
`define COUNT_W 8

`endif

// File: hw/sifhPkg.sv
`default_nettype none

`include "sifh_config.svh"

package sifhPkg;

    // vectors with a meaning of their own
    typedef logic [`TS_W-1:0] tsT;
    typedef logic [`BIN_W-1:0] binT;
    typedef logic [`PIX_W-1:0] pixT;
    typedef logic [`COUNT_W-1:0] countT;

    // fine window start for every pixel of the group
    typedef tsT [`PIX_NUM-1:0] windowArrT;

    // histogram memory phases
    typedef enum logic [1:0] {
        COLLECT,
        SCAN,
        EMIT
    } histStateT;

endpackage

`default_nettype wire

// File: hw/sifhIf.sv
`timescale 1ns/1ps
`default_nettype none

// ********************************************************************
// bin records from the filter to the histogram memory
// ********************************************************************
interface binBusIf;
    import sifhPkg::*;

    logic valid;
    logic ready;
    pixT pixel;
    binT bin;
    // final record of a pass
    logic last;

    modport src (output valid, output pixel, output bin, output last, input ready);
    modport dst (input valid, input pixel, input bin, input last, output ready);
endinterface

// ********************************************************************
// peak bins from the histogram memory to the window calculator
// ********************************************************************
interface peakBusIf;
    import sifhPkg::*;

    logic valid;
    logic ready;
    pixT pixel;
    binT bin;

    modport src (output valid, output pixel, output bin, input ready);
    modport dst (input valid, input pixel, input bin, output ready);
endinterface

`default_nettype wire

// File: hw/dataFilter.sv
`timescale 1ns/1ps
`default_nettype none

`include "sifh_config.svh"

module dataFilter (
    input  wire logic               clk,
    input  wire logic               combin_res,
    input  wire logic               sampleValid,
    output logic                    sampleReady,
    input  wire sifhPkg::tsT        sampleTime,
    input  wire sifhPkg::windowArrT windowLow,
    input  wire logic               windowsValid,
    binBusIf.src                    binOut
);
    import sifhPkg::*;

    localparam int SAMP_W = (`DATA_NUM > 1) ? $clog2(`DATA_NUM) : 1;
    localparam int ACQ_W = (`ACQ_NUM > 1) ? $clog2(`ACQ_NUM) : 1;

    // stream position
    logic [SAMP_W-1:0] sampleCnt;
    pixT pixCnt;
    logic [ACQ_W-1:0] acqCnt;
    // 0 coarse, 1 fine
    logic passBit;

    logic accept;
    logic lastSample;
    logic inWindow;
    logic keepSample;
    tsT winStart;
    tsT winOffset;
    binT coarseBin;
    binT fineBin;
    binT selBin;

    // one-deep output register
    logic outValid;
    pixT outPixel;
    binT outBin;
    logic outLast;

    // free slot, and in fine pass only once windows are known
    assign sampleReady = (!outValid || binOut.ready) && (!passBit || windowsValid);
    assign accept = sampleValid && sampleReady;

    assign lastSample = (sampleCnt == SAMP_W'(`DATA_NUM - 1)) &&
                        (pixCnt == pixT'(`PIX_NUM - 1)) &&
                        (acqCnt == ACQ_W'(`ACQ_NUM - 1));

    always_comb begin
        winStart = windowLow[pixCnt];
        winOffset = sampleTime - winStart;
        // top bits give the coarse bin
        coarseBin = sampleTime[`TS_W-1 -: `BIN_W];
        fineBin = winOffset[`BIN_W-1:0];
        // offset must fit in one bin index
        inWindow = (sampleTime >= winStart) && (winOffset < tsT'(1 << `BIN_W));
        selBin = passBit ? fineBin : coarseBin;
        keepSample = !passBit || inWindow;
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixCnt <= '0;
            acqCnt <= '0;
            passBit <= 1'b0;
            outValid <= 1'b0;
        end else begin
            if (accept) begin
                // dropped samples leave the slot empty, a dropped last still closes the pass
                outValid <= keepSample || lastSample;
                if (sampleCnt == SAMP_W'(`DATA_NUM - 1)) begin
                    sampleCnt <= '0;
                    if (pixCnt == pixT'(`PIX_NUM - 1)) begin
                        pixCnt <= '0;
                        if (acqCnt == ACQ_W'(`ACQ_NUM - 1)) begin
                            acqCnt <= '0;
                            passBit <= ~passBit;
                        end else begin
                            acqCnt <= acqCnt + 1'b1;
                        end
                    end else begin
                        pixCnt <= pixCnt + 1'b1;
                    end
                end else begin
                    sampleCnt <= sampleCnt + 1'b1;
                end
            end else if (binOut.ready) begin
                outValid <= 1'b0;
            end
        end
    end

    // record payload
    always_ff @(posedge clk) begin
        if (accept) begin
            if (keepSample) begin
                outPixel <= pixCnt;
                outBin <= selBin;
            end else begin
                // all ones pixel and bin mark a non-counting last record
                outPixel <= '1;
                outBin <= '1;
            end
            outLast <= lastSample;
        end
    end

    assign binOut.valid = outValid;
    assign binOut.pixel = outPixel;
    assign binOut.bin = outBin;
    assign binOut.last = outLast;

endmodule

`default_nettype wire

// File: hw/histogramRam.sv
`timescale 1ns/1ps
`default_nettype none

`include "sifh_config.svh"

module histogramRam (
    input wire logic clk,
    input wire logic combin_res,
    binBusIf.dst     binIn,
    peakBusIf.src    peakOut
);
    import sifhPkg::*;

    localparam int BIN_NUM = 1 << `BIN_W;
    localparam int CELL_NUM = `PIX_NUM * BIN_NUM;
    localparam int ADDR_W = `PIX_W + `BIN_W;

    histStateT state;

    // counts for all pixels, pixel index in the upper address bits
    countT binCount [CELL_NUM];

    // scan walks every cell once
    logic [ADDR_W-1:0] scanAddr;
    pixT scanPix;
    binT scanBin;
    countT scanVal;
    countT runMax;

    // best bin per pixel, sent in EMIT
    binT peakBin [`PIX_NUM];
    pixT emitPix;

    logic [ADDR_W-1:0] wrAddr;
    logic recTake;
    logic noCount;
    logic emitTake;

    assign binIn.ready = (state == COLLECT);
    assign recTake = binIn.valid && (state == COLLECT);
    assign wrAddr = {binIn.pixel, binIn.bin};
    // marker pair only means something on a last record
    assign noCount = binIn.last && (&binIn.pixel) && (&binIn.bin);

    assign scanPix = scanAddr[ADDR_W-1 -: `PIX_W];
    assign scanBin = scanAddr[`BIN_W-1:0];
    assign scanVal = binCount[scanAddr];

    assign emitTake = (state == EMIT) && peakOut.ready;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state <= COLLECT;
            scanAddr <= '0;
            runMax <= '0;
            emitPix <= '0;
            for (int i = 0; i < CELL_NUM; i++) begin
                binCount[i] <= '0;
            end
            for (int p = 0; p < `PIX_NUM; p++) begin
                peakBin[p] <= '0;
            end
        end else begin
            case (state)
                // ************************************************************
                // accumulate one record per cycle
                // ************************************************************
                COLLECT: begin
                    if (recTake) begin
                        // saturate at all ones
                        if (!noCount && (binCount[wrAddr] != '1)) begin
                            binCount[wrAddr] <= binCount[wrAddr] + 1'b1;
                        end
                        if (binIn.last) begin
                            state <= SCAN;
                            scanAddr <= '0;
                        end
                    end
                end
                // ************************************************************
                // read and clear, track the peak
                // ************************************************************
                SCAN: begin
                    binCount[scanAddr] <= '0;
                    if (scanBin == '0) begin
                        // new pixel starts at bin 0
                        runMax <= scanVal;
                        peakBin[scanPix] <= '0;
                    end else if (scanVal > runMax) begin
                        // strictly greater keeps the lowest bin on ties
                        runMax <= scanVal;
                        peakBin[scanPix] <= scanBin;
                    end
                    if (scanAddr == ADDR_W'(CELL_NUM - 1)) begin
                        state <= EMIT;
                        emitPix <= '0;
                    end
                    scanAddr <= scanAddr + 1'b1;
                end
                // ************************************************************
                // hand out peaks in pixel order
                // ************************************************************
                EMIT: begin
                    if (emitTake) begin
                        if (emitPix == pixT'(`PIX_NUM - 1)) begin
                            state <= COLLECT;
                            emitPix <= '0;
                        end else begin
                            emitPix <= emitPix + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= COLLECT;
                end
            endcase
        end
    end

    assign peakOut.valid = (state == EMIT);
    assign peakOut.pixel = emitPix;
    assign peakOut.bin = peakBin[emitPix];

endmodule

`default_nettype wire

// File: hw/windowCalc.sv
`timescale 1ns/1ps
`default_nettype none

`include "sifh_config.svh"

module windowCalc (
    input  wire logic          clk,
    input  wire logic          combin_res,
    peakBusIf.dst              peakIn,
    output sifhPkg::windowArrT windowLow,
    output logic               windowsValid,
    output logic               resultValid,
    input  wire logic          resultReady,
    output sifhPkg::pixT       resultPixel,
    output sifhPkg::tsT        resultTime
);
    import sifhPkg::*;

    // highest start that still leaves a full window
    localparam int WIN_MAX = (1 << `TS_W) - (1 << `BIN_W);
    localparam int HALF_BIN = 1 << (`BIN_W - 1);

    // pass of the incoming peaks
    logic passBit;
    pixT peakCnt;
    pixT resCnt;

    logic peakTake;
    logic resTake;
    tsT winStart;

    // coarse bin to a window centred on it, kept inside the code range
    function automatic tsT clampWindow(input binT coarse);
        int start;
        start = (int'(coarse) << (`TS_W - `BIN_W)) - HALF_BIN;
        if (start < 0) begin
            start = 0;
        end else if (start > WIN_MAX) begin
            start = WIN_MAX;
        end
        return tsT'(start);
    endfunction

    // fine peaks wait for a free result slot
    assign peakIn.ready = !passBit || !resultValid || resultReady;
    assign peakTake = peakIn.valid && peakIn.ready;
    assign resTake = resultValid && resultReady;
    assign winStart = clampWindow(peakIn.bin);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            passBit <= 1'b0;
            peakCnt <= '0;
            resCnt <= '0;
            windowsValid <= 1'b0;
            resultValid <= 1'b0;
            windowLow <= '0;
        end else begin
            if (resTake) begin
                resultValid <= 1'b0;
                // windows retire with the last result of the frame
                if (resCnt == pixT'(`PIX_NUM - 1)) begin
                    resCnt <= '0;
                    windowsValid <= 1'b0;
                end else begin
                    resCnt <= resCnt + 1'b1;
                end
            end
            if (peakTake) begin
                if (!passBit) begin
                    windowLow[peakIn.pixel] <= winStart;
                end else begin
                    resultValid <= 1'b1;
                end
                if (peakCnt == pixT'(`PIX_NUM - 1)) begin
                    peakCnt <= '0;
                    passBit <= ~passBit;
                    if (!passBit) begin
                        windowsValid <= 1'b1;
                    end
                end else begin
                    peakCnt <= peakCnt + 1'b1;
                end
            end
        end
    end

    // final time is window start plus fine peak
    always_ff @(posedge clk) begin
        if (peakTake && passBit) begin
            resultPixel <= peakIn.pixel;
            resultTime <= windowLow[peakIn.pixel] + tsT'(peakIn.bin);
        end
    end

endmodule

`default_nettype wire

// File: hw/sifhTop.sv
`timescale 1ns/1ps
`default_nettype none

module sifhTop (
    input  wire logic    clk,
    input  wire logic    combin_res,
    // timestamp stream in
    input  wire logic    sampleValid,
    output logic         sampleReady,
    input  wire sifhPkg::tsT sampleTime,
    // per-pixel time stream out
    output logic         resultValid,
    input  wire logic    resultReady,
    output sifhPkg::pixT resultPixel,
    output sifhPkg::tsT  resultTime
);
    import sifhPkg::*;

    // window feedback from the calculator to the filter
    windowArrT windowLow;
    logic windowsValid;

    binBusIf binBus ();
    peakBusIf peakBus ();

    // ********************************************************************
    // filter, histogram memory, window calculator
    // ********************************************************************
    dataFilter filter_i (
        .clk          (clk),
        .combin_res   (combin_res),
        .sampleValid  (sampleValid),
        .sampleReady  (sampleReady),
        .sampleTime   (sampleTime),
        .windowLow    (windowLow),
        .windowsValid (windowsValid),
        .binOut       (binBus.src)
    );

    histogramRam hist_i (
        .clk        (clk),
        .combin_res (combin_res),
        .binIn      (binBus.dst),
        .peakOut    (peakBus.src)
    );

    windowCalc calc_i (
        .clk          (clk),
        .combin_res   (combin_res),
        .peakIn       (peakBus.dst),
        .windowLow    (windowLow),
        .windowsValid (windowsValid),
        .resultValid  (resultValid),
        .resultReady  (resultReady),
        .resultPixel  (resultPixel),
        .resultTime   (resultTime)
    );

endmodule

`default_nettype wire

// File: verif/sifhTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sifh_config.svh"

module sifhTb;
    import sifhPkg::*;

    // samples of one frame, both passes
    localparam int SAMPLE_NUM = 2 * `ACQ_NUM * `PIX_NUM * `DATA_NUM;
    localparam int PASS_SAMPLES = SAMPLE_NUM / 2;
    localparam int FRAME_WORDS = SAMPLE_NUM + `PIX_NUM;
    localparam int MAX_FRAMES = 3;
    localparam int MEM_WORDS = 1 + MAX_FRAMES * FRAME_WORDS;
    localparam int RESET_CYCLES = 4;
    localparam int DRAIN_CYCLES = 16;
    // worst case per frame with gaps and stalls
    localparam int FRAME_CYCLES = 2 * PASS_SAMPLES * 4 + 2 * `PIX_NUM * (1 << `BIN_W) + 64;

    logic clk;
    logic combin_res;
    logic sampleValid;
    logic sampleReady;
    tsT sampleTime;
    logic resultValid;
    logic resultReady;
    pixT resultPixel;
    tsT resultTime;

    // frame count, then per frame the timestamps and the expected times
    logic [15:0] goldenMem [MEM_WORDS];
    tsT stimTime [$];
    tsT expTime [$];

    integer seed;
    int frameNum;
    int errCount = 0;
    int testErrStart = 0;
    int passCount = 0;
    int failCount = 0;
    int resultCount = 0;
    int cycleCount = 0;
    int cycleLimit = 0;
    logic running = 1'b0;
    logic sampleTaken = 1'b0;

    sifhTop dut_i (
        .clk         (clk),
        .combin_res  (combin_res),
        .sampleValid (sampleValid),
        .sampleReady (sampleReady),
        .sampleTime  (sampleTime),
        .resultValid (resultValid),
        .resultReady (resultReady),
        .resultPixel (resultPixel),
        .resultTime  (resultTime)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // **********************************************************************
    // helpers
    // **********************************************************************
    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            errCount++;
        end
    endtask

    // one line per finished test
    task automatic finishTest(input string name);
        if (errCount == testErrStart) begin
            $display("%s: ok", name);
            passCount++;
        end else begin
            $display("%s: %0d mismatches", name, errCount - testErrStart);
            failCount++;
        end
        testErrStart = errCount;
    endtask

    // split the golden words into stimulus and expected queues
    task automatic loadGolden();
        int base;
        if (frameNum < 1 || frameNum > MAX_FRAMES) begin
            $display("golden file frame count %0d is out of range", frameNum);
            errCount++;
            frameNum = 0;
        end
        for (int f = 0; f < frameNum; f++) begin
            base = 1 + f * FRAME_WORDS;
            for (int i = 0; i < SAMPLE_NUM; i++) begin
                stimTime.push_back(tsT'(goldenMem[base + i]));
            end
            for (int p = 0; p < `PIX_NUM; p++) begin
                expTime.push_back(tsT'(goldenMem[base + SAMPLE_NUM + p]));
            end
        end
    endtask

    // frames back to back, random idle cycles in and stalls out
    task automatic streamFrames();
        int idx;
        int total;
        idx = 0;
        total = frameNum * `PIX_NUM;
        while (resultCount < total) begin
            @(posedge clk);
            #2;
            // transfer seen at the last negedge happened on this edge
            if (sampleTaken) begin
                sampleValid = 1'b0;
                idx++;
            end
            resultReady = (($random(seed) & 3) != 0);
            if (!sampleValid && idx < stimTime.size()) begin
                if (($random(seed) & 3) != 0) begin
                    sampleValid = 1'b1;
                    sampleTime = stimTime[idx];
                end
            end
        end
        sampleValid = 1'b0;
    endtask

    // **********************************************************************
    // result monitor, mid-cycle where all handshakes are stable
    // **********************************************************************
    always @(negedge clk) begin
        sampleTaken = sampleValid && sampleReady;
        if (running && resultValid && resultReady) begin
            if (resultCount >= expTime.size()) begin
                $display("a result arrived after all expected results were seen");
                errCount++;
            end else begin
                checkValue("resultPixel", resultPixel, resultCount % `PIX_NUM);
                checkValue("resultTime", resultTime, expTime[resultCount]);
            end
            resultCount++;
            if (resultCount % `PIX_NUM == 0) begin
                finishTest($sformatf("frame %0d", resultCount / `PIX_NUM));
            end
        end
    end

    // run limit
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("Timeout: results did not arrive within %0d cycles", cycleLimit);
            $display("Simulation failed");
            $finish;
        end
    end

    // **********************************************************************
    // main sequence
    // **********************************************************************
    initial begin
        combin_res = 1'b0;
        sampleValid = 1'b0;
        sampleTime = '0;
        resultReady = 1'b0;
        seed = 32'h442c_2700;
        $readmemh("verif/sifh_golden.hex", goldenMem);
        frameNum = goldenMem[0];
        loadGolden();
        cycleLimit = RESET_CYCLES + 64 + frameNum * FRAME_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        combin_res = 1'b1;
        @(negedge clk);
        checkValue("resultValid", resultValid, 0);
        checkValue("sampleReady", sampleReady, 1);
        finishTest("reset state");

        running = 1'b1;
        streamFrames();
        // catch any duplicate result
        repeat (DRAIN_CYCLES) begin
            @(posedge clk);
            #2;
            resultReady = 1'b1;
        end

        $display("%0d tests passed, %0d tests failed", passCount, failCount);
        if (failCount == 0 && errCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/sifh_golden.hex
// word 0 frame count; per frame 4 lines of timestamps (2 acquisitions each, pixel 0..3,
// 2 samples per pixel), pass 0 then pass 1, then one line of expected times for pixels 0..3
003
// frame 1, mid-range peaks
101 10A 203 207 2C1 2C4 384 38A 104 10F 20B 200 2C8 2CC 381 388
108 230 20E 3A0 2C2 150 38E 0A0 10C 050 205 209 2CF 2C0 383 38C
105 105 1F8 1F8 2D7 2D7 36C 36C 105 0F0 1F8 210 2B0 2D7 36C 390
105 110 1F8 1F0 2D7 2A0 36C 39F 105 0E3 21F 1F8 2DF 2C5 360 36C
105 1F8 2D7 36C
// frame 2, windows clamped at both ends
002 00F 011 01C 3E4 3EA 3F1 3FF 005 00A 015 018 3E1 3EE 3F8 3F4
000 200 01F 010 120 3E7 3FC 3F0 00C 007 013 300 3E9 3E3 080 3F6
03A 03A 008 008 3FE 3FE 3C4 3C4 03A 010 020 008 3C0 3FE 3C4 3F0
000 03A 008 03F 3FE 3FF 3FF 3C4 03F 03A 001 008 3D0 3FE 3C4 3C0
03A 008 3FE 3C4
// frame 3, dropped samples, ties, empty fine histogram, dropped last sample
101 10A 203 207 2C1 2C4 388 381 104 10F 20B 200 2C8 2CC 38F 38A
108 230 20E 3A0 2C2 150 302 30E 10C 050 205 209 2CF 2C0 305 309
300 110 205 205 000 100 2E8 2E8 300 120 1F2 210 2E0 29F 385 2E8
110 300 1F2 205 3FF 2E5 2E8 31F 300 110 210 1F2 050 1A0 300 3A0
110 1F2 2A0 2E8

// File: sim.f
+incdir+hw
hw/sifhPkg.sv
hw/sifhIf.sv
hw/dataFilter.sv
hw/histogramRam.sv
hw/windowCalc.sv
hw/sifhTop.sv
verif/sifhTb.sv

// File: Bender.yml
package:
  name: sifh

sources:
  - include_dirs:
      - hw
    files:
      - hw/sifhPkg.sv
      - hw/sifhIf.sv
      - hw/dataFilter.sv
      - hw/histogramRam.sv
      - hw/windowCalc.sv
      - hw/sifhTop.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - verif/sifhTb.sv
